// ==== filelist.f ====
source/rate_ctrl_pkg.sv
source/mult_arbiter.sv
source/axis_pid.sv
source/body_frame_controller.sv
source/rate_controller_top.sv
tests/rate_controller_props.sv
tests/rate_controller_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rate_controller_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/rate_controller_tb.sv ====
`timescale 1ns/1ps

module rate_controller_tb;

	import rate_ctrl_pkg::*;

	localparam int N_ROWS          = 12;
	localparam int RESET_CYCLES    = 10;
	localparam int DONE_TIMEOUT    = 40;
	localparam int QUIET_CYCLES    = 20;
	localparam int WATCHDOG_CYCLES = N_ROWS * 50 + 3 * RESET_CYCLES + QUIET_CYCLES;
	localparam int ACT_NORMAL      = 0;
	localparam int ACT_BUSY        = 1;
	localparam int ACT_RESET       = 2;
	localparam int ACT_RANDOM      = 3;
	localparam int SAT_LO          = -32768;
	localparam int SAT_HI          = 32767;

	logic                     start_signal;
	logic                     resetn;
	logic                     cycle_start;
	logic signed [RATE_W-1:0] in_val [8];
	logic signed [RATE_W-1:0] roll_rate_out;
	logic signed [RATE_W-1:0] pitch_rate_out;
	logic signed [RATE_W-1:0] yaw_rate_out;
	logic                     busy;
	logic                     cycle_done;

	// column order is roll, pitch, yaw target then roll, pitch, yaw rotation
	// then roll, pitch angle error, values in 12.4 where 16 is 1.0
	int row_val [N_ROWS][8] = '{
		'{160, 80, -64, 0, 0, 0, 0, 0},
		'{160, 80, -64, 0, 0, 0, 0, 0},
		'{160, 80, -64, 0, 0, 0, 0, 0},
		'{160, 80, -64, 0, 0, 0, 0, 0},
		'{160, 80, -64, 40, -16, 48, 24, -32},
		'{-200, 120, 96, -80, 200, -30, -48, 64},
		'{32000, 32000, 32000, -32000, -32000, -32000, 16000, 16000},
		'{-32000, -32000, -32000, 32000, 32000, 32000, -16000, -16000},
		'{320, -160, 80, 16, 16, 16, 0, 0},
		'{160, 80, -64, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 0, 0, 0, 0}
	};
	int row_act [N_ROWS] = '{ACT_NORMAL, ACT_NORMAL, ACT_NORMAL, ACT_NORMAL, ACT_NORMAL,
		ACT_NORMAL, ACT_NORMAL, ACT_NORMAL, ACT_BUSY, ACT_RESET, ACT_RANDOM, ACT_RANDOM};

	// reference model state and constants per axis
	logic signed [RATE_W-1:0] kp_g [N_AXES] = '{ROLL_KP, PITCH_KP, YAW_KP};
	logic signed [RATE_W-1:0] ki_g [N_AXES] = '{ROLL_KI, PITCH_KI, YAW_KI};
	logic signed [RATE_W-1:0] kd_g [N_AXES] = '{ROLL_KD, PITCH_KD, YAW_KD};
	logic signed [RATE_W-1:0] lo_lim [N_AXES] = '{ROLL_RATE_MIN, PITCH_RATE_MIN, YAW_RATE_MIN};
	logic signed [RATE_W-1:0] hi_lim [N_AXES] = '{ROLL_RATE_MAX, PITCH_RATE_MAX, YAW_RATE_MAX};
	int integ_m [N_AXES];
	int prev_m [N_AXES];

	int          error_count = 0;
	int          check_count = 0;
	int          done_count  = 0;
	logic [31:0] rng_state   = 32'd44404;

	rate_controller_top rate_controller_top_inst (
		.start_signal      (start_signal),
		.resetn            (resetn),
		.cycle_start       (cycle_start),
		.roll_target       (in_val[0]),
		.pitch_target      (in_val[1]),
		.yaw_target        (in_val[2]),
		.roll_rotation     (in_val[3]),
		.pitch_rotation    (in_val[4]),
		.yaw_rotation      (in_val[5]),
		.roll_angle_error  (in_val[6]),
		.pitch_angle_error (in_val[7]),
		.roll_rate_out     (roll_rate_out),
		.pitch_rate_out    (pitch_rate_out),
		.yaw_rate_out      (yaw_rate_out),
		.busy              (busy),
		.cycle_done        (cycle_done)
	);

	initial begin
		start_signal = 1'b0;
		forever #5 start_signal = ~start_signal;
	end

	// cycle_done is stable at the falling edge
	always @(negedge start_signal)
		if (cycle_done)
			done_count++;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic signed [RATE_W-1:0] rand_rate();
		rng_state = xorshift32(rng_state);
		return rng_state[RATE_W-1:0];
	endfunction

	function automatic int clip(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// one PID step for one axis with saturation at every stage
	function automatic int model_update(input int ax, input int err);
		int diff;
		int integ_n;
		int sum;
		diff    = clip(err - prev_m[ax], SAT_LO, SAT_HI);
		integ_n = clip(integ_m[ax] + err, SAT_LO, SAT_HI);
		sum     = int'(kp_g[ax]) * err + int'(ki_g[ax]) * integ_n + int'(kd_g[ax]) * diff;
		integ_m[ax] = integ_n;
		prev_m[ax]  = err;
		return clip(sum >>> FRAC_BITS, int'(lo_lim[ax]), int'(hi_lim[ax]));
	endfunction

	task automatic check_output(input string name, input logic signed [RATE_W-1:0] got,
			input logic signed [RATE_W-1:0] exp);
		check_count++;
		assert (got == exp) else begin
			error_count++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic apply_reset();
		@(posedge start_signal);
		#1;
		resetn      = 1'b0;
		cycle_start = 1'b0;
		repeat (RESET_CYCLES) @(posedge start_signal);
		#1;
		resetn = 1'b1;
		for (int ax = 0; ax < N_AXES; ax++) begin
			integ_m[ax] = 0;
			prev_m[ax]  = 0;
		end
		check_output("roll_rate_out", roll_rate_out, '0);
		check_output("pitch_rate_out", pitch_rate_out, '0);
		check_output("yaw_rate_out", yaw_rate_out, '0);
		assert (!busy && !cycle_done) else begin
			error_count++;
			$display("%0t busy or cycle_done is high right after reset", $time);
		end
	endtask

	task automatic wait_done(output bit seen);
		int n;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < DONE_TIMEOUT) begin
			@(posedge start_signal);
			#1;
			n++;
			if (cycle_done)
				seen = 1'b1;
		end
	endtask

	task automatic run_row(input int r);
		int                       err [N_AXES];
		logic signed [RATE_W-1:0] exp_v [N_AXES];
		int                       done_before;
		bit                       seen;
		if (row_act[r] == ACT_RESET)
			apply_reset();
		if (row_act[r] == ACT_RANDOM)
			for (int k = 0; k < 8; k++)
				row_val[r][k] = int'(rand_rate());
		err[AXIS_ROLL]  = clip(row_val[r][0] - row_val[r][3] + row_val[r][6], SAT_LO, SAT_HI);
		err[AXIS_PITCH] = clip(row_val[r][1] - row_val[r][4] + row_val[r][7], SAT_LO, SAT_HI);
		err[AXIS_YAW]   = clip(row_val[r][2] - row_val[r][5], SAT_LO, SAT_HI);
		for (int ax = 0; ax < N_AXES; ax++)
			exp_v[ax] = 16'(model_update(ax, err[ax]));
		@(posedge start_signal);
		#1;
		done_before = done_count;
		for (int k = 0; k < 8; k++)
			in_val[k] = 16'(row_val[r][k]);
		cycle_start = 1'b1;
		@(posedge start_signal);
		#1;
		cycle_start = 1'b0;
		if (row_act[r] == ACT_BUSY) begin
			// a second start with other inputs that the DUT must ignore
			assert (busy) else begin
				error_count++;
				$display("%0t busy was low when the second start was driven", $time);
			end
			for (int k = 0; k < 8; k++)
				in_val[k] = rand_rate();
			cycle_start = 1'b1;
			@(posedge start_signal);
			#1;
			cycle_start = 1'b0;
		end
		wait_done(seen);
		assert (seen) else begin
			error_count++;
			$display("%0t row %0d: cycle_done did not arrive within %0d cycles", $time, r,
				DONE_TIMEOUT);
		end
		check_output("roll_rate_out", roll_rate_out, exp_v[AXIS_ROLL]);
		check_output("pitch_rate_out", pitch_rate_out, exp_v[AXIS_PITCH]);
		check_output("yaw_rate_out", yaw_rate_out, exp_v[AXIS_YAW]);
		if (row_act[r] == ACT_BUSY) begin
			repeat (QUIET_CYCLES) @(posedge start_signal);
			#1;
			check_count++;
			assert (done_count == done_before + 1) else begin
				error_count++;
				$display("%0t row %0d: expected one cycle_done, saw %0d", $time, r,
					done_count - done_before);
			end
		end
	endtask

	initial begin
		resetn      = 1'b0;
		cycle_start = 1'b0;
		for (int k = 0; k < 8; k++)
			in_val[k] = '0;
		apply_reset();
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge start_signal);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tests/rate_controller_props.sv ====
`timescale 1ns/1ps

module rate_controller_props (
	input logic                             start_signal,
	input logic                             resetn,
	input logic [rate_ctrl_pkg::N_AXES-1:0] mul_grant,
	input logic [rate_ctrl_pkg::N_AXES-1:0] mul_valid,
	input logic                             busy,
	input logic                             cycle_done
);

	// at most one owner of the multiplier per cycle
	grant_onehot: assert property (@(posedge start_signal) disable iff (!resetn)
		$onehot0(mul_grant))
		else $error("mul_grant has more than one bit set");

	// product goes back to the granted owner one cycle later
	grant_to_valid: assert property (@(posedge start_signal) disable iff (!resetn)
		(|mul_grant) |=> (mul_valid == $past(mul_grant)))
		else $error("mul_valid does not match the grant of the previous cycle");

	done_single: assert property (@(posedge start_signal) disable iff (!resetn)
		cycle_done |=> !cycle_done)
		else $error("cycle_done stayed high for more than one cycle");

	done_with_busy_fall: assert property (@(posedge start_signal) disable iff (!resetn)
		cycle_done |-> (!busy && $past(busy)))
		else $error("cycle_done did not coincide with busy falling");

endmodule

// top level sees both the arbiter bus and the sequencer status
bind rate_controller_top rate_controller_props rate_controller_props_inst (
	.start_signal (start_signal),
	.resetn       (resetn),
	.mul_grant    (mul_grant),
	.mul_valid    (mul_valid),
	.busy         (busy),
	.cycle_done   (cycle_done)
);

// ==== source/rate_controller_top.sv ====
`timescale 1ns/1ps

module rate_controller_top (
	input  logic                                    start_signal,
	input  logic                                    resetn,
	input  logic                                    cycle_start,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_angle_error,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_angle_error,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_rate_out,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rate_out,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rate_out,
	output logic                                    busy,
	output logic                                    cycle_done
);

	import rate_ctrl_pkg::*;

	logic                     compute;
	logic signed [RATE_W-1:0] roll_error;
	logic signed [RATE_W-1:0] pitch_error;
	logic signed [RATE_W-1:0] yaw_error;
	logic                     roll_done;
	logic                     pitch_done;
	logic                     yaw_done;

	// shared multiplier bus, indexed by axis
	logic [N_AXES-1:0]        mul_req;
	logic [N_AXES-1:0]        mul_grant;
	logic [N_AXES-1:0]        mul_valid;
	logic signed [PROD_W-1:0] mul_product;
	logic signed [RATE_W-1:0] roll_mul_a;
	logic signed [RATE_W-1:0] roll_mul_b;
	logic signed [RATE_W-1:0] pitch_mul_a;
	logic signed [RATE_W-1:0] pitch_mul_b;
	logic signed [RATE_W-1:0] yaw_mul_a;
	logic signed [RATE_W-1:0] yaw_mul_b;

	body_frame_controller body_frame_controller_inst (
		.start_signal      (start_signal),
		.resetn            (resetn),
		.cycle_start       (cycle_start),
		.roll_target       (roll_target),
		.pitch_target      (pitch_target),
		.yaw_target        (yaw_target),
		.roll_rotation     (roll_rotation),
		.pitch_rotation    (pitch_rotation),
		.yaw_rotation      (yaw_rotation),
		.roll_angle_error  (roll_angle_error),
		.pitch_angle_error (pitch_angle_error),
		.roll_done         (roll_done),
		.pitch_done        (pitch_done),
		.yaw_done          (yaw_done),
		.compute           (compute),
		.roll_error        (roll_error),
		.pitch_error       (pitch_error),
		.yaw_error         (yaw_error),
		.busy              (busy),
		.cycle_done        (cycle_done)
	);

	axis_pid #(
		.kp       (ROLL_KP),
		.ki       (ROLL_KI),
		.kd       (ROLL_KD),
		.rate_min (ROLL_RATE_MIN),
		.rate_max (ROLL_RATE_MAX)
	) roll_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.compute      (compute),
		.error        (roll_error),
		.mul_grant    (mul_grant[AXIS_ROLL]),
		.mul_valid    (mul_valid[AXIS_ROLL]),
		.mul_product  (mul_product),
		.mul_req      (mul_req[AXIS_ROLL]),
		.mul_a        (roll_mul_a),
		.mul_b        (roll_mul_b),
		.rate_out     (roll_rate_out),
		.pid_done     (roll_done)
	);

	axis_pid #(
		.kp       (PITCH_KP),
		.ki       (PITCH_KI),
		.kd       (PITCH_KD),
		.rate_min (PITCH_RATE_MIN),
		.rate_max (PITCH_RATE_MAX)
	) pitch_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.compute      (compute),
		.error        (pitch_error),
		.mul_grant    (mul_grant[AXIS_PITCH]),
		.mul_valid    (mul_valid[AXIS_PITCH]),
		.mul_product  (mul_product),
		.mul_req      (mul_req[AXIS_PITCH]),
		.mul_a        (pitch_mul_a),
		.mul_b        (pitch_mul_b),
		.rate_out     (pitch_rate_out),
		.pid_done     (pitch_done)
	);

	axis_pid #(
		.kp       (YAW_KP),
		.ki       (YAW_KI),
		.kd       (YAW_KD),
		.rate_min (YAW_RATE_MIN),
		.rate_max (YAW_RATE_MAX)
	) yaw_pid (
		.start_signal (start_signal),
		.resetn       (resetn),
		.compute      (compute),
		.error        (yaw_error),
		.mul_grant    (mul_grant[AXIS_YAW]),
		.mul_valid    (mul_valid[AXIS_YAW]),
		.mul_product  (mul_product),
		.mul_req      (mul_req[AXIS_YAW]),
		.mul_a        (yaw_mul_a),
		.mul_b        (yaw_mul_b),
		.rate_out     (yaw_rate_out),
		.pid_done     (yaw_done)
	);

	// requester n of the arbiter is axis n
	mult_arbiter mult_arbiter_inst (
		.start_signal (start_signal),
		.resetn       (resetn),
		.mul_req      (mul_req),
		.mul_a_0      (roll_mul_a),
		.mul_b_0      (roll_mul_b),
		.mul_a_1      (pitch_mul_a),
		.mul_b_1      (pitch_mul_b),
		.mul_a_2      (yaw_mul_a),
		.mul_b_2      (yaw_mul_b),
		.mul_grant    (mul_grant),
		.mul_valid    (mul_valid),
		.mul_product  (mul_product)
	);

endmodule

// ==== source/body_frame_controller.sv ====
`timescale 1ns/1ps

module body_frame_controller (
	input  logic                                    start_signal,
	input  logic                                    resetn,
	input  logic                                    cycle_start,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_target,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_rotation,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_angle_error,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_angle_error,
	input  logic                                    roll_done,
	input  logic                                    pitch_done,
	input  logic                                    yaw_done,
	output logic                                    compute,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] roll_error,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] pitch_error,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] yaw_error,
	output logic                                    busy,
	output logic                                    cycle_done
);

	import rate_ctrl_pkg::*;

	typedef enum logic [1:0] {
		S_WAITING,
		S_STARTING,
		S_ACTIVE,
		S_COMPLETE
	} seq_state_t;

	seq_state_t state;

	logic signed [RATE_W-1:0] lat_roll_target;
	logic signed [RATE_W-1:0] lat_pitch_target;
	logic signed [RATE_W-1:0] lat_yaw_target;
	logic signed [RATE_W-1:0] lat_roll_rotation;
	logic signed [RATE_W-1:0] lat_pitch_rotation;
	logic signed [RATE_W-1:0] lat_yaw_rotation;
	logic signed [RATE_W-1:0] lat_roll_angle;
	logic signed [RATE_W-1:0] lat_pitch_angle;

	logic [N_AXES-1:0] done_in;
	logic [N_AXES-1:0] done_flags;
	logic              start_accept;

	// the complete cycle already counts as idle
	assign start_accept = cycle_start && (state == S_WAITING || state == S_COMPLETE);

	assign done_in[AXIS_ROLL]  = roll_done;
	assign done_in[AXIS_PITCH] = pitch_done;
	assign done_in[AXIS_YAW]   = yaw_done;

	always_ff @(posedge start_signal) begin
		if (start_accept) begin
			lat_roll_target    <= roll_target;
			lat_pitch_target   <= pitch_target;
			lat_yaw_target     <= yaw_target;
			lat_roll_rotation  <= roll_rotation;
			lat_pitch_rotation <= pitch_rotation;
			lat_yaw_rotation   <= yaw_rotation;
			lat_roll_angle     <= roll_angle_error;
			lat_pitch_angle    <= pitch_angle_error;
		end
		// errors go out together with compute; yaw has no angle term
		if (state == S_STARTING) begin
			roll_error  <= sat_rate(ACC_W'(lat_roll_target) - ACC_W'(lat_roll_rotation)
				+ ACC_W'(lat_roll_angle));
			pitch_error <= sat_rate(ACC_W'(lat_pitch_target) - ACC_W'(lat_pitch_rotation)
				+ ACC_W'(lat_pitch_angle));
			yaw_error   <= sat_rate(ACC_W'(lat_yaw_target) - ACC_W'(lat_yaw_rotation));
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state      <= S_WAITING;
			compute    <= 1'b0;
			busy       <= 1'b0;
			cycle_done <= 1'b0;
			done_flags <= '0;
		end else begin
			compute    <= 1'b0;
			cycle_done <= 1'b0;
			case (state)
				S_WAITING, S_COMPLETE: begin
					if (start_accept) begin
						state      <= S_STARTING;
						busy       <= 1'b1;
						done_flags <= '0;
					end else begin
						state <= S_WAITING;
					end
				end
				S_STARTING: begin
					state   <= S_ACTIVE;
					compute <= 1'b1;
				end
				S_ACTIVE: begin
					// sticky per-axis completion
					done_flags <= done_flags | done_in;
					if (&done_flags) begin
						state      <= S_COMPLETE;
						busy       <= 1'b0;
						cycle_done <= 1'b1;
					end
				end
				default: state <= S_WAITING;
			endcase
		end
	end

endmodule

// ==== source/axis_pid.sv ====
`timescale 1ns/1ps

module axis_pid #(
	parameter logic signed [rate_ctrl_pkg::RATE_W-1:0] kp       = 16'sd16,
	parameter logic signed [rate_ctrl_pkg::RATE_W-1:0] ki       = 16'sd0,
	parameter logic signed [rate_ctrl_pkg::RATE_W-1:0] kd       = 16'sd0,
	parameter logic signed [rate_ctrl_pkg::RATE_W-1:0] rate_min = -16'sd16000,
	parameter logic signed [rate_ctrl_pkg::RATE_W-1:0] rate_max = 16'sd16000
) (
	input  logic                                    start_signal,
	input  logic                                    resetn,
	input  logic                                    compute,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0] error,
	input  logic                                    mul_grant,
	input  logic                                    mul_valid,
	input  logic signed [rate_ctrl_pkg::PROD_W-1:0] mul_product,
	output logic                                    mul_req,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] mul_a,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] mul_b,
	output logic signed [rate_ctrl_pkg::RATE_W-1:0] rate_out,
	output logic                                    pid_done
);

	import rate_ctrl_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT
	} pid_state_t;

	typedef enum logic [1:0] {
		TERM_P,
		TERM_I,
		TERM_D
	} term_t;

	pid_state_t state;
	term_t      term;

	// state kept between control cycles
	logic signed [RATE_W-1:0] integ;
	logic signed [RATE_W-1:0] prev_err;

	// working values for the cycle in progress
	logic signed [RATE_W-1:0] integ_new;
	logic signed [RATE_W-1:0] diff;
	logic signed [ACC_W-1:0]  acc;
	logic signed [ACC_W-1:0]  acc_sum;
	logic signed [ACC_W-1:0]  acc_shift;
	logic signed [RATE_W-1:0] clamped;

	assign mul_req = (state == S_REQ);

	// operand pair for the term being requested
	always_comb begin
		case (term)
			TERM_P: begin
				mul_a = kp;
				mul_b = error;
			end
			TERM_I: begin
				mul_a = ki;
				mul_b = integ_new;
			end
			default: begin
				mul_a = kd;
				mul_b = diff;
			end
		endcase
	end

	assign acc_sum   = acc + ACC_W'(mul_product);
	assign acc_shift = acc_sum >>> FRAC_BITS;

	always_comb begin
		if (acc_shift > ACC_W'(rate_max))
			clamped = rate_max;
		else if (acc_shift < ACC_W'(rate_min))
			clamped = rate_min;
		else
			clamped = acc_shift[RATE_W-1:0];
	end

	always_ff @(posedge start_signal) begin
		if (state == S_IDLE && compute) begin
			integ_new <= sat_rate(ACC_W'(integ) + ACC_W'(error));
			diff      <= sat_rate(ACC_W'(error) - ACC_W'(prev_err));
			acc       <= '0;
		end else if (state == S_WAIT && mul_valid) begin
			acc <= acc_sum;
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state    <= S_IDLE;
			term     <= TERM_P;
			pid_done <= 1'b0;
			rate_out <= '0;
			integ    <= '0;
			prev_err <= '0;
		end else begin
			pid_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (compute) begin
						state <= S_REQ;
						term  <= TERM_P;
					end
				end
				S_REQ: begin
					// request drops the cycle after the grant
					if (mul_grant)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (mul_valid) begin
						if (term == TERM_D) begin
							state    <= S_IDLE;
							rate_out <= clamped;
							pid_done <= 1'b1;
							integ    <= integ_new;
							prev_err <= error;
						end else begin
							state <= S_REQ;
							term  <= (term == TERM_P) ? TERM_I : TERM_D;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== source/mult_arbiter.sv ====
`timescale 1ns/1ps

module mult_arbiter (
	input  logic                                        start_signal,
	input  logic                                        resetn,
	input  logic [rate_ctrl_pkg::N_AXES-1:0]            mul_req,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_a_0,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_b_0,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_a_1,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_b_1,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_a_2,
	input  logic signed [rate_ctrl_pkg::RATE_W-1:0]     mul_b_2,
	output logic [rate_ctrl_pkg::N_AXES-1:0]            mul_grant,
	output logic [rate_ctrl_pkg::N_AXES-1:0]            mul_valid,
	output logic signed [rate_ctrl_pkg::PROD_W-1:0]     mul_product
);

	import rate_ctrl_pkg::*;

	logic signed [RATE_W-1:0] op_a [N_AXES];
	logic signed [RATE_W-1:0] op_b [N_AXES];
	logic [IDX_W-1:0]         last_idx;
	logic [IDX_W-1:0]         grant_idx;
	logic                     any_req;

	assign op_a[0] = mul_a_0;
	assign op_b[0] = mul_b_0;
	assign op_a[1] = mul_a_1;
	assign op_b[1] = mul_b_1;
	assign op_a[2] = mul_a_2;
	assign op_b[2] = mul_b_2;

	// search starts just after the last winner; nearest requester wins
	always_comb begin
		grant_idx = last_idx;
		any_req   = 1'b0;
		for (int i = N_AXES; i >= 1; i--) begin
			if (mul_req[IDX_W'((int'(last_idx) + i) % N_AXES)]) begin
				grant_idx = IDX_W'((int'(last_idx) + i) % N_AXES);
				any_req   = 1'b1;
			end
		end
	end

	always_comb begin
		mul_grant = '0;
		if (any_req)
			mul_grant[grant_idx] = 1'b1;
	end

	// pointer and owner tag
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			last_idx  <= IDX_W'(N_AXES - 1);
			mul_valid <= '0;
		end else begin
			mul_valid <= mul_grant;
			if (any_req)
				last_idx <= grant_idx;
		end
	end

	// one product per cycle, handed to its owner on the next cycle
	always_ff @(posedge start_signal) begin
		if (any_req)
			mul_product <= op_a[grant_idx] * op_b[grant_idx];
	end

endmodule

// ==== source/rate_ctrl_pkg.sv ====
package rate_ctrl_pkg;

	// all rates, errors and gains are signed 12.4 fixed point
	localparam int RATE_W    = 16;
	localparam int FRAC_BITS = 4;
	localparam int PROD_W    = 32;
	localparam int ACC_W     = 34;

	// axes double as multiplier requester indices
	localparam int N_AXES     = 3;
	localparam int IDX_W      = 2;
	localparam int AXIS_ROLL  = 0;
	localparam int AXIS_PITCH = 1;
	localparam int AXIS_YAW   = 2;

	// gains, 1.0 is 16
	localparam logic signed [RATE_W-1:0] ROLL_KP  = 16'sd32;
	localparam logic signed [RATE_W-1:0] ROLL_KI  = 16'sd4;
	localparam logic signed [RATE_W-1:0] ROLL_KD  = 16'sd8;
	localparam logic signed [RATE_W-1:0] PITCH_KP = 16'sd24;
	localparam logic signed [RATE_W-1:0] PITCH_KI = 16'sd2;
	localparam logic signed [RATE_W-1:0] PITCH_KD = 16'sd4;
	localparam logic signed [RATE_W-1:0] YAW_KP   = 16'sd16;
	localparam logic signed [RATE_W-1:0] YAW_KI   = 16'sd1;
	localparam logic signed [RATE_W-1:0] YAW_KD   = 16'sd0;

	// output limits, +-1000.0 and +-500.0
	localparam logic signed [RATE_W-1:0] ROLL_RATE_MIN  = -16'sd16000;
	localparam logic signed [RATE_W-1:0] ROLL_RATE_MAX  = 16'sd16000;
	localparam logic signed [RATE_W-1:0] PITCH_RATE_MIN = -16'sd16000;
	localparam logic signed [RATE_W-1:0] PITCH_RATE_MAX = 16'sd16000;
	localparam logic signed [RATE_W-1:0] YAW_RATE_MIN   = -16'sd8000;
	localparam logic signed [RATE_W-1:0] YAW_RATE_MAX   = 16'sd8000;

	// full range of the 16-bit format
	localparam logic signed [RATE_W-1:0] RATE_SAT_MAX = 16'sh7fff;
	localparam logic signed [RATE_W-1:0] RATE_SAT_MIN = -16'sh8000;

	// clamp a wide sum into the 16-bit rate format
	function automatic logic signed [RATE_W-1:0] sat_rate(input logic signed [ACC_W-1:0] value);
		if (value > ACC_W'(RATE_SAT_MAX))
			return RATE_SAT_MAX;
		else if (value < ACC_W'(RATE_SAT_MIN))
			return RATE_SAT_MIN;
		return value[RATE_W-1:0];
	endfunction

endpackage
